//--- hdl/ex_config.svh
/*
 * Global sizes of the execute stage. The multiplier is written for 32-bit words
 * split into 16-bit halves over four steps, so these values are not free to change.
 */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path width, one register word
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Half word that the multiplier steps over
`define EX_HALF_W 16

// Shift amount taken from the low bits of operand B
`define EX_SHAMT_W 5

// Partial-product cycles per multiply
`define EX_MUL_STEPS 4

`endif

//--- hdl/ex_pkg.sv
/*
 * Operation word shared by decode, ALU and multiplier. The unit enables select which
 * view of the word is meaningful, and the unused view carries no information.
 */
`include "ex_config.svh"

package ex_pkg;

  ////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////

  // Arithmetic, logic and shifts first, branch comparisons from 0x10 up
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_SLT  = 5'h08,
    ALU_SLTU = 5'h09,
    ALU_EQ   = 5'h10,
    ALU_NE   = 5'h11,
    ALU_LT   = 5'h12,
    ALU_GE   = 5'h13,
    ALU_LTU  = 5'h14,
    ALU_GEU  = 5'h15
  } alu_op_e;

  // Multiplier signedness, bit 0 for operand A and bit 1 for operand B
  typedef enum logic [1:0] {
    MUL_UU = 2'b00,
    MUL_SU = 2'b01,
    MUL_SS = 2'b11
  } mul_mode_e;

  // Multiplier view of the operation word
  typedef struct packed {
    logic      high;
    mul_mode_e mode;
    logic [1:0] spare;
  } mul_op_t;

  // One 5-bit word, read as ALU operator or as multiplier control
  typedef union packed {
    alu_op_e alu;
    mul_op_t mul;
  } ex_op_u;

endpackage

//--- hdl/ex_alu.sv
/*
 * Single-cycle ALU. The shift amount is the low bits of operand B only, and
 * cmp_result_o is meaningful only for branch and set-less-than operators.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_alu (
  input  ex_pkg::ex_op_u       op_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  // Shared adder
  logic                  adder_sub;
  logic [`EX_XLEN:0]     adder_sum;
  logic                  is_equal;
  logic                  lt_signed;
  logic                  lt_unsigned;

  // Shifter
  logic                  shift_left;
  logic                  shift_arith;
  logic [`EX_XLEN-1:0]   operand_a_rev;
  logic [`EX_XLEN-1:0]   shift_in;
  logic signed [`EX_XLEN:0] shift_ext;
  logic signed [`EX_XLEN:0] shift_out;
  logic [`EX_XLEN-1:0]   shift_right_res;
  logic [`EX_XLEN-1:0]   shift_right_rev;
  logic [`EX_XLEN-1:0]   shift_res;

  ////////////////////////////////////////
  // Adder and comparisons
  ////////////////////////////////////////

  // Only ADD adds, every other adder user subtracts
  assign adder_sub = (op_i.alu != ex_pkg::ALU_ADD);

  // Extra top bit keeps the carry out for unsigned compare
  assign adder_sum = {1'b0, operand_a_i}
                   + {1'b0, operand_b_i ^ {`EX_XLEN{adder_sub}}}
                   + {{`EX_XLEN{1'b0}}, adder_sub};

  assign is_equal    = (adder_sum[`EX_XLEN-1:0] == '0);
  // No carry out of A - B means A below B
  assign lt_unsigned = !adder_sum[`EX_XLEN];
  // Same signs: difference sign decides, else A's sign does
  assign lt_signed   = (operand_a_i[`EX_XLEN-1] == operand_b_i[`EX_XLEN-1]) ?
                       adder_sum[`EX_XLEN-1] : operand_a_i[`EX_XLEN-1];

  ////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////

  assign shift_left  = (op_i.alu == ex_pkg::ALU_SLL);
  assign shift_arith = (op_i.alu == ex_pkg::ALU_SRA);

  // Left shift done as right shift on the bit-reversed operand
  assign operand_a_rev = {<<{operand_a_i}};
  assign shift_in      = shift_left ? operand_a_rev : operand_a_i;

  // Fill bit is the sign only for SRA
  assign shift_ext = {shift_arith & shift_in[`EX_XLEN-1], shift_in};
  assign shift_out = shift_ext >>> operand_b_i[`EX_SHAMT_W-1:0];

  assign shift_right_res = shift_out[`EX_XLEN-1:0];
  assign shift_right_rev = {<<{shift_right_res}};
  assign shift_res       = shift_left ? shift_right_rev : shift_right_res;

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (op_i.alu)
      ex_pkg::ALU_EQ:   cmp_result_o = is_equal;
      ex_pkg::ALU_NE:   cmp_result_o = !is_equal;
      ex_pkg::ALU_LT,
      ex_pkg::ALU_SLT:  cmp_result_o = lt_signed;
      ex_pkg::ALU_GE:   cmp_result_o = !lt_signed;
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_SLTU: cmp_result_o = lt_unsigned;
      ex_pkg::ALU_GEU:  cmp_result_o = !lt_unsigned;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i.alu)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB: result_o = adder_sum[`EX_XLEN-1:0];
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA: result_o = shift_res;
      // SLT, SLTU and branch compares give 0 or 1
      default:         result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- hdl/ex_mult.sv
/*
 * Iterative multiplier, one 16x16 partial product per cycle. Operands and op_i
 * are read on every step, so they must stay stable until the result is taken.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  logic                ready_i,
  input  ex_pkg::ex_op_u      op_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                valid_o,
  output logic                ready_o
);

  // Step counter and result-held flag
  logic [$clog2(`EX_MUL_STEPS)-1:0] step_q;
  logic                             done_q;
  logic                             idle;

  // Operand halves and partial product
  logic                             a_signed;
  logic                             b_signed;
  logic signed [`EX_HALF_W:0]       a_half;
  logic signed [`EX_HALF_W:0]       b_half;
  logic signed [2*`EX_HALF_W+1:0]   pp;
  logic [2*`EX_XLEN-1:0]            pp_ext;
  logic [1:0]                       half_shift;
  logic [2*`EX_XLEN-1:0]            pp_shifted;

  // Double-width accumulator
  logic [2*`EX_XLEN-1:0]            acc_base;
  logic [2*`EX_XLEN-1:0]            acc_next;
  logic [2*`EX_XLEN-1:0]            acc_q;

  ////////////////////////////////////////
  // Partial products
  ////////////////////////////////////////

  assign a_signed = (op_i.mul.mode == ex_pkg::MUL_SU) || (op_i.mul.mode == ex_pkg::MUL_SS);
  assign b_signed = (op_i.mul.mode == ex_pkg::MUL_SS);

  // Step bit 0 picks A's half, bit 1 picks B's half
  // Upper halves carry the sign, lower halves are zero-extended
  assign a_half = step_q[0] ? {a_signed & op_a_i[`EX_XLEN-1], op_a_i[`EX_XLEN-1:`EX_HALF_W]}
                            : {1'b0, op_a_i[`EX_HALF_W-1:0]};
  assign b_half = step_q[1] ? {b_signed & op_b_i[`EX_XLEN-1], op_b_i[`EX_XLEN-1:`EX_HALF_W]}
                            : {1'b0, op_b_i[`EX_HALF_W-1:0]};

  assign pp = a_half * b_half;

  assign pp_ext = {{(2*`EX_XLEN-2*`EX_HALF_W-2){pp[2*`EX_HALF_W+1]}}, pp};

  // Weight of the product in half words: 0, 1, 1, 2
  assign half_shift = {1'b0, step_q[0]} + {1'b0, step_q[1]};
  assign pp_shifted = pp_ext << (`EX_HALF_W * half_shift);

  // First step starts from zero
  assign acc_base = (step_q == '0) ? '0 : acc_q;
  assign acc_next = acc_base + pp_shifted;

  always_ff @(posedge clk) begin
    if (valid_i && !done_q) begin
      acc_q <= acc_next;
    end
  end

  ////////////////////////////////////////
  // Step control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
      done_q <= 1'b0;
    end else if (!valid_i) begin
      // Dropped request (kill or halt) aborts
      step_q <= '0;
      done_q <= 1'b0;
    end else if (done_q) begin
      // Hold result until write-back takes it
      if (ready_i) begin
        done_q <= 1'b0;
      end
    end else begin
      step_q <= step_q + 1'b1;
      if (step_q == `EX_MUL_STEPS - 1) begin
        step_q <= '0;
        done_q <= 1'b1;
      end
    end
  end

  assign idle = (step_q == '0) && !done_q;

  assign valid_o = done_q;
  assign ready_o = (idle && !valid_i) || (done_q && ready_i);

  // MUL takes the low word, MULH* the high word
  assign result_o = op_i.mul.high ? acc_q[2*`EX_XLEN-1:`EX_XLEN] : acc_q[`EX_XLEN-1:0];

endmodule

//--- hdl/ex_ctrl.sv
/*
 * Stage control, purely combinational. Decode must keep its inputs stable while
 * ex_ready_o is low, since the multiplier reads them on every step.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_ctrl (
  input  logic                instr_valid_i,
  input  logic                alu_en_i,
  input  logic                mul_en_i,
  input  logic                branch_i,
  input  logic                kill_i,
  input  logic                halt_i,
  input  logic                dataindtiming_i,
  input  logic                wb_ready_i,
  input  logic                mul_valid_i,
  input  logic                mul_ready_i,
  input  logic                alu_cmp_i,
  input  logic [`EX_XLEN-1:0] alu_result_i,
  input  logic [`EX_XLEN-1:0] mul_result_i,
  input  logic [`EX_XLEN-1:0] branch_target_i,
  input  logic [`EX_XLEN-1:0] pc_next_i,
  output logic                mul_start_o,
  output logic                ex_valid_o,
  output logic                ex_ready_o,
  output logic                branch_decision_o,
  output logic                bch_taken_o,
  output logic [`EX_XLEN-1:0] branch_target_o,
  output logic [`EX_XLEN-1:0] rf_wdata_o
);

  logic live_valid;

  // Instruction present and neither killed nor halted
  assign live_valid = instr_valid_i && !kill_i && !halt_i;

  // A dropped start makes the multiplier abort
  assign mul_start_o = live_valid && mul_en_i;

  // ALU and branch finish in the same cycle
  assign ex_valid_o = live_valid && (alu_en_i || branch_i || (mul_en_i && mul_valid_i));

  // Kill always frees the stage
  assign ex_ready_o = kill_i || (wb_ready_i && mul_ready_i && !halt_i);

  // Forwarding value to decode
  assign rf_wdata_o = mul_en_i ? mul_result_i : alu_result_i;

  ////////////////////////////////////////
  // Branch decision and target
  ////////////////////////////////////////

  always_comb begin
    if (dataindtiming_i) begin
      // Always redirect, to the real target or the fall-through PC
      branch_decision_o = 1'b1;
      branch_target_o   = alu_cmp_i ? branch_target_i : pc_next_i;
    end else begin
      branch_decision_o = alu_cmp_i;
      branch_target_o   = branch_target_i;
    end
  end

  // Real outcome, kept for write-back in either mode
  assign bch_taken_o = branch_i && alu_cmp_i;

endmodule

//--- hdl/ex_wb_reg.sv
/*
 * EX/WB pipeline register. Address and data only change for instructions that
 * write the register file, so they keep stale values behind non-writing ones.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_wb_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  rf_we_i,
  input  logic                  bch_taken_i,
  input  logic [`EX_RADDR_W-1:0] rf_waddr_i,
  input  logic [`EX_XLEN-1:0]   rf_wdata_i,
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic                  wb_bch_taken_o,
  output logic [`EX_RADDR_W-1:0] wb_rf_waddr_o,
  output logic [`EX_XLEN-1:0]   wb_rf_wdata_o
);

  logic capture;

  // Handoff from EX into WB
  assign capture = ex_valid_i && wb_ready_i;

  ////////////////////////////////////////
  // Valid and per-instruction flags
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (capture) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= rf_we_i;
      wb_bch_taken_o <= bch_taken_i;
    end else if (wb_ready_i) begin
      // Nothing to hand over, insert a bubble
      wb_valid_o <= 1'b0;
    end
    // wb_ready_i low holds everything
  end

  ////////////////////////////////////////
  // Write-back address and data
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_rf_waddr_o <= '0;
      wb_rf_wdata_o <= '0;
    end else if (capture && rf_we_i) begin
      // Enable doubles as clock-gate condition
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata_i;
    end
  end

endmodule

//--- hdl/ex_stage.sv
/*
 * Execute stage top. Decode holds all inputs until an edge with ex_ready_o high;
 * kill and halt come from the controller and act in the same cycle.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // From decode
  input  logic                   instr_valid_i,
  input  logic                   alu_en_i,
  input  logic                   mul_en_i,
  input  logic                   branch_i,
  input  ex_pkg::ex_op_u         op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_XLEN-1:0]    branch_target_i,
  input  logic [`EX_XLEN-1:0]    pc_next_i,
  input  logic                   rf_we_i,
  input  logic [`EX_RADDR_W-1:0] rf_waddr_i,
  // From controller
  input  logic                   kill_i,
  input  logic                   halt_i,
  input  logic                   dataindtiming_i,
  // Stage handshake
  input  logic                   wb_ready_i,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  // To fetch and decode
  output logic                   branch_decision_o,
  output logic [`EX_XLEN-1:0]    branch_target_o,
  output logic [`EX_XLEN-1:0]    rf_wdata_o,
  // EX/WB register
  output logic                   wb_valid_o,
  output logic                   wb_rf_we_o,
  output logic                   wb_bch_taken_o,
  output logic [`EX_RADDR_W-1:0] wb_rf_waddr_o,
  output logic [`EX_XLEN-1:0]    wb_rf_wdata_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mul_result;
  logic                mul_start;
  logic                mul_valid;
  logic                mul_ready;
  logic                bch_taken;

  ex_alu alu0 (
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Multiplier result is taken by the same ready as the WB register
  ex_mult mult0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (mul_start),
    .ready_i  (wb_ready_i),
    .op_i     (op_i),
    .op_a_i   (operand_a_i),
    .op_b_i   (operand_b_i),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_o  (mul_ready)
  );

  ex_ctrl ctrl0 (
    .instr_valid_i     (instr_valid_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .branch_i          (branch_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .dataindtiming_i   (dataindtiming_i),
    .wb_ready_i        (wb_ready_i),
    .mul_valid_i       (mul_valid),
    .mul_ready_i       (mul_ready),
    .alu_cmp_i         (alu_cmp),
    .alu_result_i      (alu_result),
    .mul_result_i      (mul_result),
    .branch_target_i   (branch_target_i),
    .pc_next_i         (pc_next_i),
    .mul_start_o       (mul_start),
    .ex_valid_o        (ex_valid_o),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .bch_taken_o       (bch_taken),
    .branch_target_o   (branch_target_o),
    .rf_wdata_o        (rf_wdata_o)
  );

  ex_wb_reg wb_reg0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_o),
    .wb_ready_i     (wb_ready_i),
    .rf_we_i        (rf_we_i),
    .bch_taken_i    (bch_taken),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (rf_wdata_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_bch_taken_o (wb_bch_taken_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o)
  );

endmodule

//--- testbench/ex_stage_sva.sv
/*
 * Protocol assertions for the execute stage, bound into ex_stage.
 * Sampled on the rising clock edge; reset disables all but the reset check.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage_sva (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   kill_i,
  input logic                   wb_ready_i,
  input logic                   ex_ready_o,
  input logic                   ex_valid_o,
  input logic                   wb_valid_o,
  input logic                   wb_rf_we_o,
  input logic                   wb_bch_taken_o,
  input logic [`EX_RADDR_W-1:0] wb_rf_waddr_o,
  input logic [`EX_XLEN-1:0]    wb_rf_wdata_o
);

  // Number of failed assertions
  int unsigned assert_fails = 0;

  // A killed instruction leaves a bubble in WB
  kill_leaves_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    (kill_i && wb_ready_i) |=> !wb_valid_o)
    else begin
      assert_fails = assert_fails + 1;
      $error("killed instruction reached the WB register");
    end

  // Decode is released on the same edge that WB captures the result
  valid_taken_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && wb_ready_i) |-> ex_ready_o)
    else begin
      assert_fails = assert_fails + 1;
      $error("ex_valid_o and wb_ready_i high while ex_ready_o low");
    end

  // WB register holds under back-pressure
  wb_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable({wb_valid_o, wb_rf_we_o, wb_bch_taken_o,
                             wb_rf_waddr_o, wb_rf_wdata_o}))
    else begin
      assert_fails = assert_fails + 1;
      $error("WB outputs changed while wb_ready_i low");
    end

  // Empty pipeline right out of reset
  wb_empty_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !wb_valid_o)
    else begin
      assert_fails = assert_fails + 1;
      $error("wb_valid_o high in first cycle after reset");
    end

endmodule

bind ex_stage ex_stage_sva sva0 (
  .clk            (clk),
  .rst_n          (rst_n),
  .kill_i         (kill_i),
  .wb_ready_i     (wb_ready_i),
  .ex_ready_o     (ex_ready_o),
  .ex_valid_o     (ex_valid_o),
  .wb_valid_o     (wb_valid_o),
  .wb_rf_we_o     (wb_rf_we_o),
  .wb_bch_taken_o (wb_bch_taken_o),
  .wb_rf_waddr_o  (wb_rf_waddr_o),
  .wb_rf_wdata_o  (wb_rf_wdata_o)
);

//--- testbench/tb_ex_stage.sv
/*
 * Execute stage testbench. Lines come from testbench/ex_testdata.mem, run from the
 * project root. A killed multiply is killed two cycles after it is presented.
 */
`timescale 1ns/1ns
`include "ex_config.svh"

module tb_ex_stage;

  // One data line, see field slices in run_line
  localparam int LINE_W    = 220;
  localparam int MAX_LINES = 64;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid_i;
  logic                   alu_en_i;
  logic                   mul_en_i;
  logic                   branch_i;
  ex_pkg::ex_op_u         op_i;
  logic [`EX_XLEN-1:0]    operand_a_i;
  logic [`EX_XLEN-1:0]    operand_b_i;
  logic [`EX_XLEN-1:0]    branch_target_i;
  logic [`EX_XLEN-1:0]    pc_next_i;
  logic                   rf_we_i;
  logic [`EX_RADDR_W-1:0] rf_waddr_i;
  logic                   kill_i;
  logic                   halt_i;
  logic                   dataindtiming_i;
  logic                   wb_ready_i;
  logic                   ex_ready_o;
  logic                   ex_valid_o;
  logic                   branch_decision_o;
  logic [`EX_XLEN-1:0]    branch_target_o;
  logic [`EX_XLEN-1:0]    rf_wdata_o;
  logic                   wb_valid_o;
  logic                   wb_rf_we_o;
  logic                   wb_bch_taken_o;
  logic [`EX_RADDR_W-1:0] wb_rf_waddr_o;
  logic [`EX_XLEN-1:0]    wb_rf_wdata_o;

  logic [LINE_W-1:0] lines [0:MAX_LINES-1];
  int                num_lines;
  int                cycle_count;
  int                cycle_limit;
  logic              running;

  // Expected WB record: we, rd, data, taken
  logic [38:0]       exp_q [$];

  ex_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "check failed");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  // Cycle budget guards against a hang
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      abort_run("timeout, the stage stopped making progress");
    end
  end

  // Random back-pressure from write-back
  always @(negedge clk) begin
    if (running) begin
      wb_ready_i = (($urandom % 4) != 0);
    end
  end

  // WB monitor, a record is consumed on an edge with wb_ready_i high
  always @(posedge clk) begin
    logic [38:0] rec;
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("write-back record arrived with no instruction outstanding");
      end
      rec = exp_q.pop_front();
      check_eq(wb_rf_we_o, rec[38], "wb_rf_we_o");
      check_eq(wb_bch_taken_o, rec[0], "wb_bch_taken_o");
      if (rec[38]) begin
        check_eq(wb_rf_waddr_o, rec[37:33], "wb_rf_waddr_o");
        check_eq(wb_rf_wdata_o, rec[32:1], "wb_rf_wdata_o");
      end
    end
  end

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////

  task automatic run_line(input int idx);
    logic [LINE_W-1:0] ln;
    logic [3:0]        unit;
    logic [3:0]        flags;
    logic [3:0]        dec;
    logic [31:0]       exp_res;
    logic [31:0]       exp_tgt;
    logic              killed;
    logic              accepted;
    int                cyc;
    int                kill_at;
    ln       = lines[idx];
    unit     = ln[219:216];
    flags    = ln[79:76];
    exp_res  = ln[67:36];
    dec      = ln[35:32];
    exp_tgt  = ln[31:0];
    killed   = flags[0];
    // Multiply is killed mid-operation, others at once
    kill_at  = (unit == 4'd1) ? 2 : 0;
    accepted = 1'b0;
    cyc      = 0;

    instr_valid_i   = 1'b1;
    alu_en_i        = (unit == 4'd0);
    mul_en_i        = (unit == 4'd1);
    branch_i        = (unit == 4'd2);
    op_i            = ln[212:208];
    operand_a_i     = ln[207:176];
    operand_b_i     = ln[175:144];
    branch_target_i = ln[143:112];
    pc_next_i       = ln[111:80];
    dataindtiming_i = flags[1];
    rf_we_i         = flags[2];
    rf_waddr_i      = ln[72:68];
    kill_i          = killed && (kill_at == 0);

    while (!accepted) begin
      @(posedge clk);
      if (ex_ready_o) begin
        accepted = 1'b1;
        if (!killed) begin
          check_eq(ex_valid_o, 1'b1, $sformatf("ex_valid_o, line %0d", idx));
          if (unit == 4'd2) begin
            check_eq(branch_decision_o, dec[0], $sformatf("branch_decision_o, line %0d", idx));
            check_eq(branch_target_o, exp_tgt, $sformatf("branch_target_o, line %0d", idx));
          end else begin
            check_eq(rf_wdata_o, exp_res, $sformatf("rf_wdata_o, line %0d", idx));
          end
          exp_q.push_back({rf_we_i, rf_waddr_i, exp_res, dec[1]});
        end
      end else begin
        @(negedge clk);
        cyc++;
        if (killed && cyc == kill_at) begin
          kill_i = 1'b1;
        end
      end
    end
    @(negedge clk);
    kill_i = 1'b0;
  endtask

  initial begin
    void'($urandom(32'he075_d516));
    rst_n           = 1'b0;
    instr_valid_i   = 1'b0;
    alu_en_i        = 1'b0;
    mul_en_i        = 1'b0;
    branch_i        = 1'b0;
    op_i            = '0;
    operand_a_i     = '0;
    operand_b_i     = '0;
    branch_target_i = '0;
    pc_next_i       = '0;
    rf_we_i         = 1'b0;
    rf_waddr_i      = '0;
    kill_i          = 1'b0;
    halt_i          = 1'b0;
    dataindtiming_i = 1'b0;
    wb_ready_i      = 1'b1;
    running         = 1'b0;
    cycle_count     = 0;
    cycle_limit     = 0;

    // Unit field 0xf marks a slot that the file did not fill
    for (int i = 0; i < MAX_LINES; i++) begin
      lines[i] = {4'hf, (LINE_W-4)'(i)};
    end
    $readmemh("testbench/ex_testdata.mem", lines);
    num_lines = 0;
    while (num_lines < MAX_LINES && lines[num_lines][219:216] != 4'hf) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      abort_run("no test lines could be read from the data file");
    end
    cycle_limit = num_lines * (`EX_MUL_STEPS + 8) + 100;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n   = 1'b1;
    running = 1'b1;

    for (int i = 0; i < num_lines; i++) begin
      run_line(i);
    end
    instr_valid_i = 1'b0;
    alu_en_i      = 1'b0;
    mul_en_i      = 1'b0;
    branch_i      = 1'b0;

    // Drain the WB register
    while (exp_q.size() != 0 || wb_valid_o) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (dut0.sva0.assert_fails != 0) begin
      abort_run("a protocol assertion in the bound checker failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- testbench/ex_testdata.mem
// unit(0 alu,1 mul,2 branch)_op_a_b_target_pcnext_flags(0 kill,1 dit,2 we)_rd_result
// _dec(0 decision,1 taken)_exptarget
0_00_00000005_00000007_00000000_00000000_4_01_0000000c_0_00000000
0_01_00000003_00000005_00000000_00000000_4_02_fffffffe_0_00000000
0_02_f0f0ff00_0ff00ff0_00000000_00000000_4_03_00f00f00_0_00000000
0_03_f0f0ff00_0ff00ff0_00000000_00000000_4_04_fff0fff0_0_00000000
0_04_12345678_ffffffff_00000000_00000000_4_05_edcba987_0_00000000
0_05_00000001_0000003f_00000000_00000000_4_06_80000000_0_00000000
0_06_80000000_00000004_00000000_00000000_4_07_08000000_0_00000000
0_07_80000000_00000004_00000000_00000000_4_08_f8000000_0_00000000
0_08_ffffffff_00000001_00000000_00000000_4_09_00000001_0_00000000
0_09_ffffffff_00000001_00000000_00000000_4_0a_00000000_0_00000000
1_0c_00000007_00000006_00000000_00000000_4_0b_0000002a_0_00000000
1_1c_80000000_80000000_00000000_00000000_4_0c_40000000_0_00000000
1_14_ffffffff_ffffffff_00000000_00000000_4_0d_ffffffff_0_00000000
1_10_ffffffff_ffffffff_00000000_00000000_4_0e_fffffffe_0_00000000
1_0c_fffffffd_00000005_00000000_00000000_4_0f_fffffff1_0_00000000
1_0c_00000009_00000009_00000000_00000000_5_10_00000051_0_00000000
0_00_00000100_00000023_00000000_00000000_4_11_00000123_0_00000000
0_00_00000001_00000001_00000000_00000000_5_12_00000002_0_00000000
2_10_00000005_00000005_00001000_00000104_0_00_00000000_3_00001000
2_11_00000005_00000005_00002000_00000208_0_00_00000000_0_00002000
2_12_ffffffff_00000001_00003000_0000030c_2_00_00000000_3_00003000
2_15_00000001_ffffffff_00004000_00000410_2_00_00000000_1_00000410
0_04_aaaaaaaa_55555555_00000000_00000000_0_13_ffffffff_0_00000000
1_10_00010000_00010000_00000000_00000000_4_14_00000001_0_00000000

//--- src.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_ctrl.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
testbench/ex_stage_sva.sv
testbench/tb_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ex_stage
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) hdl/ex_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx '=== PASS ===' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
